// ==== hw/mxm_defs.svh ====
/*
 * Sizes shared by the matrix multiply accelerator: data word width,
 * matrix dimension, row buffer address width and AXI burst length.
 */
`ifndef MXM_DEFS_SVH
`define MXM_DEFS_SVH

`define MXM_DW         32
`define MXM_N          4
`define MXM_BUF_AW     2
// one matrix is fetched or stored as a single burst
`define MXM_BURST_LEN  16

`endif

// ==== hw/axi_pkg.sv ====
/*
 * AXI master port types: address, ID, length and data vectors and
 * the payload structs of the AR, R, AW, W and B channels.
 */
`include "mxm_defs.svh"

package axi_pkg;

    typedef logic [31:0]          axi_addr_t;
    // id 0 is matrix A, id 1 is matrix B
    typedef logic [0:0]           axi_id_t;
    typedef logic [7:0]           axi_len_t;
    typedef logic [`MXM_DW-1:0]   axi_data_t;
    typedef logic [1:0]           axi_resp_t;

    // len is beat count minus one, size and burst are fixed
    typedef struct packed {
        axi_addr_t addr;
        axi_id_t   id;
        axi_len_t  len;
    } axi_ar_t;

    typedef struct packed {
        axi_data_t data;
        axi_id_t   id;
        logic      last;
    } axi_r_t;

    typedef struct packed {
        axi_addr_t addr;
        axi_len_t  len;
    } axi_aw_t;

    typedef struct packed {
        axi_data_t data;
        logic      last;
    } axi_w_t;

    typedef struct packed {
        axi_resp_t resp;
    } axi_b_t;

endpackage

// ==== hw/mxm_pkg.sv ====
/*
 * Matrix datapath types: word, row, accumulator, buffer address and
 * the state enums of the DMA engine and the multiply engine.
 */
`include "mxm_defs.svh"

package mxm_pkg;

    typedef logic signed [`MXM_DW-1:0]    word_t;
    // element 0 in the low bits
    typedef word_t [`MXM_N-1:0]           row_t;
    typedef logic [`MXM_BUF_AW-1:0]       buf_addr_t;
    typedef logic signed [2*`MXM_DW:0]    acc_t;
    typedef acc_t [`MXM_N-1:0][`MXM_N-1:0] acc_mat_t;

    typedef enum logic [2:0] {
        DMA_IDLE, DMA_REQ_READ, DMA_LOAD, DMA_WAIT_MM,
        DMA_REQ_WRITE, DMA_WRITE_C, DMA_WAIT_RESP
    } dma_state_t;

    typedef enum logic [1:0] {MM_IDLE, MM_FETCH, MM_MAC, MM_FINISH} mm_state_t;

endpackage

// ==== hw/mat_buffer.sv ====
/*
 * Four-row matrix buffer, one write port and a registered read port.
 */
`timescale 1ns/1ns
`include "mxm_defs.svh"

module mat_buffer import mxm_pkg::*; (
    input  logic      clk,
    input  logic      wr_en_i,
    input  buf_addr_t wr_addr_i,
    input  row_t      wr_data_i,
    input  buf_addr_t rd_addr_i,
    output row_t      rd_data_o
);

    // one entry per matrix row, kept across runs
    row_t mem [`MXM_N];

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
        // read returns the old row on a same-address write
        rd_data_o <= mem[rd_addr_i];
    end

    a_wr_addr_known: assert property (@(posedge clk)
        wr_en_i |-> !$isunknown(wr_addr_i));

endmodule

// ==== hw/mat_mul_engine.sv ====
/*
 * Sequential 4x4 multiply engine: one row-times-row step per cycle
 * with four multipliers, accumulating C = A x B.
 */
`timescale 1ns/1ns
`include "mxm_defs.svh"

module mat_mul_engine import mxm_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      start_i,
    output logic      done_o,
    output buf_addr_t a_rd_addr_o,
    output buf_addr_t b_rd_addr_o,
    input  row_t      a_rd_data_i,
    input  row_t      b_rd_data_i,
    output acc_mat_t  accum_o
);

    mm_state_t  state;
    // step = {i, k}, issued one cycle ahead of mac_step
    logic [3:0] step;
    logic [3:0] mac_step;
    buf_addr_t  mac_i;
    buf_addr_t  mac_k;
    acc_mat_t   accum_q;
    logic signed [2*`MXM_DW-1:0] prod [`MXM_N];

    assign a_rd_addr_o = step[3:2];
    assign b_rd_addr_o = step[1:0];
    assign mac_i       = mac_step[3:2];
    assign mac_k       = mac_step[1:0];
    assign accum_o     = accum_q;

    // A[i][k] times row k of B
    always_comb begin
        for (int j = 0; j < `MXM_N; j++) begin
            prod[j] = word_t'(a_rd_data_i[mac_k]) * word_t'(b_rd_data_i[j]);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= MM_IDLE;
            step     <= '0;
            mac_step <= '0;
            done_o   <= 1'b0;
        end else begin
            done_o   <= 1'b0;
            mac_step <= step;
            case (state)
                MM_IDLE: begin
                    if (start_i) begin
                        state <= MM_FETCH;
                        step  <= '0;
                    end
                end
                MM_FETCH: begin
                    step  <= step + 1'b1;
                    state <= MM_MAC;
                end
                MM_MAC: begin
                    step <= step + 1'b1;
                    if (mac_step == 4'd15) begin
                        state  <= MM_FINISH;
                        done_o <= 1'b1;
                    end
                end
                default: begin
                    state <= MM_IDLE;
                end
            endcase
        end
    end

    // cleared during fetch, row i updated for all j per step
    always_ff @(posedge clk) begin
        if (state == MM_FETCH) begin
            accum_q <= '0;
        end else if (state == MM_MAC) begin
            for (int j = 0; j < `MXM_N; j++) begin
                accum_q[mac_i][j] <= accum_q[mac_i][j] + acc_t'(prod[j]);
            end
        end
    end

    a_start_in_idle: assert property (@(posedge clk) disable iff (!rst_n)
        start_i |-> state == MM_IDLE);

endmodule

// ==== hw/dma_engine.sv ====
/*
 * DMA engine: reads A and B over AXI, packs beats into buffer rows,
 * starts the multiply and writes C back as one burst.
 */
`timescale 1ns/1ns
`include "mxm_defs.svh"

module dma_engine import axi_pkg::*, mxm_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  axi_addr_t mat_a_addr_i,
    input  axi_addr_t mat_b_addr_i,
    input  axi_addr_t mat_c_addr_i,
    input  logic      start_i,
    output logic      done_o,
    output logic      ar_valid_o,
    output axi_ar_t   ar_o,
    input  logic      ar_ready_i,
    input  logic      r_valid_i,
    input  axi_r_t    r_i,
    output logic      r_ready_o,
    output logic      aw_valid_o,
    output axi_aw_t   aw_o,
    input  logic      aw_ready_i,
    output logic      w_valid_o,
    output axi_w_t    w_o,
    input  logic      w_ready_i,
    input  logic      b_valid_i,
    input  axi_b_t    b_i,
    output logic      b_ready_o,
    output logic      buf_a_wr_en_o,
    output buf_addr_t buf_a_wr_addr_o,
    output row_t      buf_a_wr_data_o,
    output logic      buf_b_wr_en_o,
    output buf_addr_t buf_b_wr_addr_o,
    output row_t      buf_b_wr_data_o,
    output logic      mm_start_o,
    input  logic      mm_done_i,
    input  acc_mat_t  accum_i
);

    dma_state_t state;
    dma_state_t state_n;
    axi_id_t    ar_id;
    // per-ID packing state, index 0 for A and 1 for B
    logic [1:0] beat_q [2];
    row_t       row_q [2];
    buf_addr_t  row_idx_q [2];
    logic       last_q [2];
    logic       wr_en_q [2];
    logic [3:0] w_cnt;
    logic       r_fire;
    logic       w_fire;

    always_comb begin
        state_n = state;
        case (state)
            DMA_IDLE: begin
                if (start_i) state_n = DMA_REQ_READ;
            end
            DMA_REQ_READ: begin
                if (ar_ready_i && ar_id == 1'b1) state_n = DMA_LOAD;
            end
            DMA_LOAD: begin
                if (last_q[0] && last_q[1]) state_n = DMA_WAIT_MM;
            end
            DMA_WAIT_MM: begin
                if (mm_done_i) state_n = DMA_REQ_WRITE;
            end
            DMA_REQ_WRITE: begin
                if (aw_ready_i) state_n = DMA_WRITE_C;
            end
            DMA_WRITE_C: begin
                if (w_fire && w_o.last) state_n = DMA_WAIT_RESP;
            end
            DMA_WAIT_RESP: begin
                if (b_valid_i) state_n = DMA_IDLE;
            end
            default: begin
                state_n = DMA_IDLE;
            end
        endcase
    end

    // A request first, B right after without waiting for data
    assign ar_valid_o = (state == DMA_REQ_READ);
    assign ar_o.addr  = ar_id ? mat_b_addr_i : mat_a_addr_i;
    assign ar_o.id    = ar_id;
    assign ar_o.len   = axi_len_t'(`MXM_BURST_LEN - 1);

    assign r_ready_o  = (state == DMA_LOAD);
    assign r_fire     = r_valid_i && r_ready_o;

    assign aw_valid_o = (state == DMA_REQ_WRITE);
    assign aw_o.addr  = mat_c_addr_i;
    assign aw_o.len   = axi_len_t'(`MXM_BURST_LEN - 1);

    // C goes out row-major, low word of each accumulator
    assign w_valid_o  = (state == DMA_WRITE_C);
    assign w_o.data   = accum_i[w_cnt[3:2]][w_cnt[1:0]][`MXM_DW-1:0];
    assign w_o.last   = (w_cnt == 4'(`MXM_BURST_LEN - 1));
    assign w_fire     = w_valid_o && w_ready_i;

    assign b_ready_o  = (state == DMA_WAIT_RESP);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= DMA_IDLE;
            ar_id      <= 1'b0;
            w_cnt      <= '0;
            mm_start_o <= 1'b0;
            done_o     <= 1'b0;
            for (int id = 0; id < 2; id++) begin
                beat_q[id]    <= '0;
                row_idx_q[id] <= '0;
                last_q[id]    <= 1'b0;
                wr_en_q[id]   <= 1'b0;
            end
        end else begin
            state      <= state_n;
            mm_start_o <= (state == DMA_LOAD) && last_q[0] && last_q[1];
            done_o     <= b_ready_o && b_valid_i;
            for (int id = 0; id < 2; id++) begin
                wr_en_q[id] <= 1'b0;
                // row address moves on once the row is written
                if (wr_en_q[id]) row_idx_q[id] <= row_idx_q[id] + 1'b1;
                if (r_fire && r_i.id == axi_id_t'(id)) begin
                    beat_q[id]  <= beat_q[id] + 1'b1;
                    wr_en_q[id] <= (beat_q[id] == 2'd3);
                    if (r_i.last) last_q[id] <= 1'b1;
                end
            end
            if (state == DMA_IDLE && start_i) begin
                ar_id <= 1'b0;
                w_cnt <= '0;
                for (int id = 0; id < 2; id++) begin
                    beat_q[id]    <= '0;
                    row_idx_q[id] <= '0;
                    last_q[id]    <= 1'b0;
                end
            end
            if (ar_valid_o && ar_ready_i) ar_id <= 1'b1;
            if (w_fire) w_cnt <= w_cnt + 1'b1;
        end
    end

    // beat lands in its word slot of the row being built
    always_ff @(posedge clk) begin
        for (int id = 0; id < 2; id++) begin
            if (r_fire && r_i.id == axi_id_t'(id)) row_q[id][beat_q[id]] <= r_i.data;
        end
    end

    assign buf_a_wr_en_o   = wr_en_q[0];
    assign buf_a_wr_addr_o = row_idx_q[0];
    assign buf_a_wr_data_o = row_q[0];
    assign buf_b_wr_en_o   = wr_en_q[1];
    assign buf_b_wr_addr_o = row_idx_q[1];
    assign buf_b_wr_data_o = row_q[1];

    a_ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_o));

    a_w_hold: assert property (@(posedge clk) disable iff (!rst_n)
        w_valid_o && !w_ready_i |=> w_valid_o && $stable(w_o));

endmodule

// ==== hw/mxm_top.sv ====
/*
 * Accelerator top: DMA engine, A and B row buffers, multiply engine.
 */
`timescale 1ns/1ns

module mxm_top import axi_pkg::*, mxm_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  axi_addr_t mat_a_addr_i,
    input  axi_addr_t mat_b_addr_i,
    input  axi_addr_t mat_c_addr_i,
    input  logic      start_i,
    output logic      done_o,
    output logic      ar_valid_o,
    output axi_ar_t   ar_o,
    input  logic      ar_ready_i,
    input  logic      r_valid_i,
    input  axi_r_t    r_i,
    output logic      r_ready_o,
    output logic      aw_valid_o,
    output axi_aw_t   aw_o,
    input  logic      aw_ready_i,
    output logic      w_valid_o,
    output axi_w_t    w_o,
    input  logic      w_ready_i,
    input  logic      b_valid_i,
    input  axi_b_t    b_i,
    output logic      b_ready_o
);

    logic      buf_a_wr_en;
    buf_addr_t buf_a_wr_addr;
    row_t      buf_a_wr_data;
    logic      buf_b_wr_en;
    buf_addr_t buf_b_wr_addr;
    row_t      buf_b_wr_data;
    buf_addr_t a_rd_addr;
    buf_addr_t b_rd_addr;
    row_t      a_rd_data;
    row_t      b_rd_data;
    logic      mm_start;
    logic      mm_done;
    acc_mat_t  accum;

    dma_engine u_dma (
        .clk             (clk),
        .rst_n           (rst_n),
        .mat_a_addr_i    (mat_a_addr_i),
        .mat_b_addr_i    (mat_b_addr_i),
        .mat_c_addr_i    (mat_c_addr_i),
        .start_i         (start_i),
        .done_o          (done_o),
        .ar_valid_o      (ar_valid_o),
        .ar_o            (ar_o),
        .ar_ready_i      (ar_ready_i),
        .r_valid_i       (r_valid_i),
        .r_i             (r_i),
        .r_ready_o       (r_ready_o),
        .aw_valid_o      (aw_valid_o),
        .aw_o            (aw_o),
        .aw_ready_i      (aw_ready_i),
        .w_valid_o       (w_valid_o),
        .w_o             (w_o),
        .w_ready_i       (w_ready_i),
        .b_valid_i       (b_valid_i),
        .b_i             (b_i),
        .b_ready_o       (b_ready_o),
        .buf_a_wr_en_o   (buf_a_wr_en),
        .buf_a_wr_addr_o (buf_a_wr_addr),
        .buf_a_wr_data_o (buf_a_wr_data),
        .buf_b_wr_en_o   (buf_b_wr_en),
        .buf_b_wr_addr_o (buf_b_wr_addr),
        .buf_b_wr_data_o (buf_b_wr_data),
        .mm_start_o      (mm_start),
        .mm_done_i       (mm_done),
        .accum_i         (accum)
    );

    mat_buffer u_buf_a (
        .clk       (clk),
        .wr_en_i   (buf_a_wr_en),
        .wr_addr_i (buf_a_wr_addr),
        .wr_data_i (buf_a_wr_data),
        .rd_addr_i (a_rd_addr),
        .rd_data_o (a_rd_data)
    );

    mat_buffer u_buf_b (
        .clk       (clk),
        .wr_en_i   (buf_b_wr_en),
        .wr_addr_i (buf_b_wr_addr),
        .wr_data_i (buf_b_wr_data),
        .rd_addr_i (b_rd_addr),
        .rd_data_o (b_rd_data)
    );

    mat_mul_engine u_mm (
        .clk         (clk),
        .rst_n       (rst_n),
        .start_i     (mm_start),
        .done_o      (mm_done),
        .a_rd_addr_o (a_rd_addr),
        .b_rd_addr_o (b_rd_addr),
        .a_rd_data_i (a_rd_data),
        .b_rd_data_i (b_rd_data),
        .accum_o     (accum)
    );

endmodule

// ==== dv/axi_mem_model.sv ====
/*
 * AXI slave memory model for the testbench: 1 KB word array, random
 * ready/valid gating, interleaved R beats and request logging.
 */
`timescale 1ns/1ns

module axi_mem_model import axi_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    ar_valid_i,
    input  axi_ar_t ar_i,
    output logic    ar_ready_o,
    output logic    r_valid_o,
    output axi_r_t  r_o,
    input  logic    r_ready_i,
    input  logic    aw_valid_i,
    input  axi_aw_t aw_i,
    output logic    aw_ready_o,
    input  logic    w_valid_i,
    input  axi_w_t  w_i,
    output logic    w_ready_o,
    output logic    b_valid_o,
    output axi_b_t  b_o,
    input  logic    b_ready_i
);

    logic [31:0] mem [256];
    logic [31:0] rnd;
    // per-ID read burst state
    logic        rd_act [2];
    axi_addr_t   rd_addr [2];
    logic [7:0]  rd_left [2];
    logic        pick;
    axi_addr_t   wr_addr;
    axi_len_t    wr_len;
    logic        wr_act;
    logic [7:0]  w_idx;

    // logged for the testbench
    int          ar_count = 0;
    int          aw_count = 0;
    int          w_count = 0;
    int          w_last_err = 0;
    int          b_count = 0;
    axi_ar_t     ar_log [8];
    axi_aw_t     aw_log [4];

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // random choice only when both bursts are open
    always_comb begin
        if (rd_act[0] && rd_act[1]) pick = rnd[7];
        else pick = rd_act[1];
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            rnd        <= 32'hb96a24e2;
            ar_ready_o <= 1'b0;
            r_valid_o  <= 1'b0;
            r_o        <= '0;
            aw_ready_o <= 1'b0;
            w_ready_o  <= 1'b0;
            b_valid_o  <= 1'b0;
            b_o        <= '0;
            rd_act[0]  <= 1'b0;
            rd_act[1]  <= 1'b0;
            wr_act     <= 1'b0;
            w_idx      <= '0;
        end else begin
            rnd        <= xorshift(rnd);
            ar_ready_o <= rnd[0] | rnd[1];
            aw_ready_o <= rnd[2] | rnd[3];
            w_ready_o  <= wr_act & (rnd[4] | rnd[5]);
            if (ar_valid_i && ar_ready_o) begin
                ar_log[ar_count % 8] <= ar_i;
                ar_count             <= ar_count + 1;
                rd_act[ar_i.id]      <= 1'b1;
                rd_addr[ar_i.id]     <= ar_i.addr;
                rd_left[ar_i.id]     <= ar_i.len;
            end
            if (r_valid_o && r_ready_i) begin
                r_valid_o         <= 1'b0;
                rd_addr[r_o.id]   <= rd_addr[r_o.id] + 32'd4;
                rd_left[r_o.id]   <= rd_left[r_o.id] - 8'd1;
                if (r_o.last) rd_act[r_o.id] <= 1'b0;
            end else if (!r_valid_o && rnd[6] && rd_act[pick]) begin
                r_valid_o <= 1'b1;
                r_o.data  <= mem[rd_addr[pick][9:2]];
                r_o.id    <= pick;
                r_o.last  <= (rd_left[pick] == 8'd0);
            end
            if (aw_valid_i && aw_ready_o) begin
                aw_log[aw_count % 4] <= aw_i;
                aw_count             <= aw_count + 1;
                wr_addr              <= aw_i.addr;
                wr_len               <= aw_i.len;
                wr_act               <= 1'b1;
                w_idx                <= '0;
            end
            if (b_valid_o && b_ready_i) begin
                b_valid_o <= 1'b0;
                b_count   <= b_count + 1;
            end
            if (w_valid_i && w_ready_o) begin
                mem[wr_addr[9:2]] <= w_i.data;
                wr_addr           <= wr_addr + 32'd4;
                w_idx             <= w_idx + 8'd1;
                w_count           <= w_count + 1;
                if (w_i.last != (w_idx == wr_len)) w_last_err <= w_last_err + 1;
                if (w_i.last) begin
                    wr_act    <= 1'b0;
                    b_valid_o <= 1'b1;
                end
            end
        end
    end

endmodule

// ==== dv/tb_mxm_top.sv ====
/*
 * Testbench for the matrix multiply accelerator: clock, reset,
 * stimulus file reader, run sequencing, checks and watchdog.
 */
`timescale 1ns/1ns

module tb_mxm_top import axi_pkg::*; ();

    localparam int        NUM_TESTS       = 2;
    localparam int        CYCLES_PER_TEST = 2000;
    localparam axi_addr_t A_ADDR          = 32'h0000_0000;
    localparam axi_addr_t B_ADDR          = 32'h0000_0100;
    localparam axi_addr_t C_ADDR          = 32'h0000_0200;

    logic    clk;
    logic    rst_n;
    logic    start;
    logic    done;
    logic    ar_valid, ar_ready, r_valid, r_ready;
    logic    aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;
    axi_ar_t ar;
    axi_r_t  r;
    axi_aw_t aw;
    axi_w_t  w;
    axi_b_t  b;

    int          errors = 0;
    int          done_count = 0;
    logic        b_hs_q = 1'b0;
    int          fd;
    string       case_name;
    logic [31:0] mat_a [16];
    logic [31:0] mat_b [16];
    logic [31:0] mat_c [16];

    mxm_top u_mxm_top (
        .clk(clk), .rst_n(rst_n),
        .mat_a_addr_i(A_ADDR), .mat_b_addr_i(B_ADDR), .mat_c_addr_i(C_ADDR),
        .start_i(start), .done_o(done),
        .ar_valid_o(ar_valid), .ar_o(ar), .ar_ready_i(ar_ready),
        .r_valid_i(r_valid), .r_i(r), .r_ready_o(r_ready),
        .aw_valid_o(aw_valid), .aw_o(aw), .aw_ready_i(aw_ready),
        .w_valid_o(w_valid), .w_o(w), .w_ready_i(w_ready),
        .b_valid_i(b_valid), .b_i(b), .b_ready_o(b_ready)
    );

    axi_mem_model u_mem (
        .clk(clk), .rst_n(rst_n),
        .ar_valid_i(ar_valid), .ar_i(ar), .ar_ready_o(ar_ready),
        .r_valid_o(r_valid), .r_o(r), .r_ready_i(r_ready),
        .aw_valid_i(aw_valid), .aw_i(aw), .aw_ready_o(aw_ready),
        .w_valid_i(w_valid), .w_i(w), .w_ready_o(w_ready),
        .b_valid_o(b_valid), .b_o(b), .b_ready_i(b_ready)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        b_hs_q <= b_valid && b_ready;
        if (done) done_count <= done_count + 1;
    end

    // done_o must follow a B handshake by one cycle
    always @(negedge clk) begin
        if (rst_n && done && !b_hs_q) begin
            $display("done_o pulsed without a preceding write response");
            errors++;
        end
    end

    initial begin
        repeat (16 + 20 + NUM_TESTS * (CYCLES_PER_TEST + 100)) @(posedge clk);
        $display("watchdog: the run did not finish within its cycle budget");
        $display("CHECKS FAILED");
        $finish;
    end

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        if (act !== exp) begin
            $display("Fail %s %s: expected %h, actual %h", case_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_quiet(input string phase);
        if (done || ar_valid || aw_valid || w_valid || r_ready || b_ready) begin
            $display("a control output went high during %s with no start", phase);
            errors++;
        end
    endtask

    // skips comment and blank lines
    task automatic next_line(output string s, output bit ok);
        int rc;
        ok = 1'b0;
        s  = "";
        rc = $fgets(s, fd);
        while (rc != 0 && (s.len() < 2 || s[0] == "#")) rc = $fgets(s, fd);
        ok = (rc != 0);
    endtask

    task automatic read_case(output bit ok);
        string       line;
        int          rc;
        logic [31:0] v [4];
        next_line(line, ok);
        if (ok) begin
            rc = $sscanf(line, "%s", case_name);
            ok = (rc == 1);
        end
        for (int row = 0; row < 12 && ok; row++) begin
            next_line(line, ok);
            if (ok) begin
                rc = $sscanf(line, "%h %h %h %h", v[0], v[1], v[2], v[3]);
                ok = (rc == 4);
            end
            for (int j = 0; j < 4; j++) begin
                if (row < 4) mat_a[row * 4 + j] = v[j];
                else if (row < 8) mat_b[(row - 4) * 4 + j] = v[j];
                else mat_c[(row - 8) * 4 + j] = v[j];
            end
        end
    endtask

    task automatic run_case(input bit busy_start);
        int ar0;
        int aw0;
        int wc0;
        int le0;
        int b0;
        int d0;
        int waited;
        // every word gets a value tied to its own address
        for (int i = 0; i < 256; i++) u_mem.mem[i] = 32'hc0de0000 ^ (i * 32'h00010001);
        for (int i = 0; i < 16; i++) begin
            u_mem.mem[A_ADDR[9:2] + i] = mat_a[i];
            u_mem.mem[B_ADDR[9:2] + i] = mat_b[i];
        end
        ar0 = u_mem.ar_count;
        aw0 = u_mem.aw_count;
        wc0 = u_mem.w_count;
        le0 = u_mem.w_last_err;
        b0  = u_mem.b_count;
        d0  = done_count;
        @(negedge clk) start = 1'b1;
        @(negedge clk) start = 1'b0;
        waited = 0;
        while (!done && waited < CYCLES_PER_TEST) begin
            @(negedge clk);
            waited++;
            start = busy_start && waited == 10;
        end
        start = 1'b0;
        if (!done) begin
            $display("%s: timed out waiting for done_o", case_name);
            errors++;
        end
        // let any stray request show up
        repeat (40) @(negedge clk);
        check_value("done pulses", 32'd1, done_count - d0);
        check_value("read requests", 32'd2, u_mem.ar_count - ar0);
        check_value("ar A addr", A_ADDR, u_mem.ar_log[ar0 % 8].addr);
        check_value("ar A id", 32'd0, 32'(u_mem.ar_log[ar0 % 8].id));
        check_value("ar A len", 32'd15, 32'(u_mem.ar_log[ar0 % 8].len));
        check_value("ar B addr", B_ADDR, u_mem.ar_log[(ar0 + 1) % 8].addr);
        check_value("ar B id", 32'd1, 32'(u_mem.ar_log[(ar0 + 1) % 8].id));
        check_value("ar B len", 32'd15, 32'(u_mem.ar_log[(ar0 + 1) % 8].len));
        check_value("write requests", 32'd1, u_mem.aw_count - aw0);
        check_value("aw addr", C_ADDR, u_mem.aw_log[aw0 % 4].addr);
        check_value("aw len", 32'd15, 32'(u_mem.aw_log[aw0 % 4].len));
        check_value("w beats", 32'd16, u_mem.w_count - wc0);
        check_value("misplaced wlast", 32'd0, u_mem.w_last_err - le0);
        check_value("write responses", 32'd1, u_mem.b_count - b0);
        for (int i = 0; i < 16; i++) begin
            check_value($sformatf("C[%0d][%0d]", i / 4, i % 4), mat_c[i],
                        u_mem.mem[C_ADDR[9:2] + i]);
        end
    endtask

    initial begin
        bit ok;
        clk   = 1'b0;
        rst_n = 1'b0;
        start = 1'b0;
        repeat (16) begin
            @(negedge clk);
            check_quiet("reset");
        end
        rst_n = 1'b1;
        repeat (20) begin
            @(negedge clk);
            check_quiet("idle after reset");
        end
        fd = $fopen("dv/mxm_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file");
            errors++;
        end else begin
            for (int t = 0; t < NUM_TESTS; t++) begin
                read_case(ok);
                if (!ok) begin
                    $display("stimulus file is short or malformed at test %0d", t);
                    errors++;
                    break;
                end
                // second case also pokes start_i while busy
                run_case(t == 1);
            end
            $fclose(fd);
        end
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== dv/mxm_stimulus.txt ====
# per test: a name line, then 4 rows of A, 4 rows of B, 4 rows of expected C
# each row holds elements 0..3 as 32-bit hex words
small_signed
00000001 00000002 00000003 00000004
ffffffff 00000000 00000002 fffffffd
00000005 fffffffe 00000001 00000000
00000000 00000007 fffffffc 00000002
00000002 00000000 ffffffff 00000001
00000001 00000003 00000000 fffffffe
fffffffe 00000001 00000004 00000000
00000000 ffffffff 00000002 00000005
fffffffe 00000005 00000013 00000011
fffffffa 00000005 00000003 fffffff0
00000006 fffffffb ffffffff 00000009
0000000f 0000000f fffffff4 fffffffc

wrap_large
00010000 00000000 00000000 00000000
00000000 80000000 00000000 00000000
00000000 00000000 7fffffff 00000000
00000001 00000001 00000001 00000001
00010001 00000000 00000000 00000003
00000000 ffffffff 00000002 00000000
00000000 00000000 7fffffff fffffffe
12345678 00000000 00000000 ffffffff
00010000 00000000 00000000 00030000
00000000 80000000 00000000 00000000
00000000 00000000 00000001 00000002
12355679 ffffffff 80000001 00000000

// ==== project.f ====
+incdir+hw
hw/axi_pkg.sv
hw/mxm_pkg.sv
hw/mat_buffer.sv
hw/mat_mul_engine.sv
hw/dma_engine.sv
hw/mxm_top.sv
dv/axi_mem_model.sv
dv/tb_mxm_top.sv

// ==== run.sh ====
#!/bin/sh
# build with Verilator and run; pass only if the pass message is printed
verilator --binary --timing -Wno-fatal -f project.f --top-module tb_mxm_top -o sim_mxm \
    && ./obj_dir/sim_mxm | tee /dev/stderr | grep -q "ALL CHECKS PASSED" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
